/* Makefile */
# Verilator build and run for the peripheral testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = peripheralTb
FILELIST = verilog.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Pass or fail decided by the log, not the exit code of the pipe
sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* bench/benchTasks.svh */
// **********************************************************************
// Bus access tasks and typed compare tasks for the peripheral testbench
// Included inside the testbench module, uses its bus signals directly
// **********************************************************************
`ifndef BENCH_TASKS_SVH
`define BENCH_TASKS_SVH

// Whole-word write, one strobe cycle
task automatic busWrite(input busWord_t addr, input busWord_t data);
    @(posedge iCLK);
    writeEnable <= 1'b1;
    address     <= addr;
    writeData   <= data;
    @(posedge iCLK);
    writeEnable <= 1'b0;
endtask

// Read strobe, then sample once the registered data has settled
task automatic busRead(input busWord_t addr, output busWord_t value);
    @(posedge iCLK);
    readEnable <= 1'b1;
    address    <= addr;
    @(posedge iCLK);
    readEnable <= 1'b0;
    // Latency of one, mid-cycle sample is safe
    @(negedge iCLK);
    value = readData;
endtask

task automatic checkWord(input string name, input busWord_t expected, input busWord_t actual);
    if (actual !== expected) begin
        $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        stopOnFailure();
    end
endtask

// Lower bound on a word, for free-running counts
task automatic checkAtLeast(input string name, input busWord_t minimum,
                            input busWord_t actual);
    if ($isunknown(actual) || actual < minimum) begin
        $display("CHECK FAILED %s expected >= %h actual %h", name, minimum, actual);
        stopOnFailure();
    end
endtask

task automatic checkSegments(input string name, input logic [SEG_WIDTH-1:0] expected,
                             input logic [SEG_WIDTH-1:0] actual);
    if (actual !== expected) begin
        $display("CHECK FAILED %s expected %b actual %b", name, expected, actual);
        stopOnFailure();
    end
endtask

task automatic checkLevel(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("CHECK FAILED %s expected %b actual %b", name, expected, actual);
        stopOnFailure();
    end
endtask

`endif

/* bench/peripheralTb.sv */
// **********************************************************************
// Testbench for the peripheral top, standing in for the processor
// Builds a stimulus table, applies it in a loop and checks each step
// **********************************************************************
`timescale 1ns/1ps

module peripheralTb import busPkg::*, displayPkg::*; ();

    localparam int       CLK_PERIOD   = 100;
    localparam int       RESET_CYCLES = 16;
    localparam busWord_t TB_SEED      = 32'h1;
    localparam int       TB_TICK_DIV  = 4;
    localparam int       MAX_STEPS    = 48;

    // Operations
    localparam int OP_READ   = 0;
    localparam int OP_WRITE  = 1;
    localparam int OP_PC     = 2;
    localparam int OP_SW     = 3;
    localparam int OP_RESUME = 4;
    localparam int OP_IDLE   = 5;

    // Check kinds
    localparam int CHK_NONE   = 0;
    localparam int CHK_WORD   = 1;
    localparam int CHK_LFSR   = 2;
    localparam int CHK_MIN    = 3;
    localparam int CHK_GEPREV = 4;
    localparam int CHK_SAME   = 5;
    localparam int CHK_LEVEL  = 6;
    localparam int CHK_DIGITS = 7;

    logic                 iCLK = 1'b0;
    logic                 arstN;
    logic                 readEnable;
    logic                 writeEnable;
    busWord_t             address;
    busWord_t             writeData;
    busWord_t             readData;
    busWord_t             pc;
    logic                 resume;
    logic [1:0]           sw;
    logic                 halt;
    logic [SEG_WIDTH-1:0] hex0, hex1, hex2, hex3, hex4, hex5;
    logic [SEG_WIDTH-1:0] hexOut [NUM_DIGITS];

    // Stimulus table with one entry per step
    string    stepName   [MAX_STEPS];
    int       stepOp     [MAX_STEPS];
    busWord_t stepAddr   [MAX_STEPS];
    busWord_t stepData   [MAX_STEPS];
    busWord_t stepExpect [MAX_STEPS];
    int       stepCheck  [MAX_STEPS];
    int       numSteps   = 0;
    logic     tableBuilt = 1'b0;
    int       seed       = 32'hbba19122;

    always #(CLK_PERIOD / 2) iCLK = ~iCLK;

    peripheralTop #(.LFSR_SEED(TB_SEED), .TICK_DIV(TB_TICK_DIV)) UUT (
        .iCLK(iCLK), .arstN(arstN),
        .readEnable(readEnable), .writeEnable(writeEnable), .address(address),
        .writeData(writeData), .readData(readData),
        .pc(pc), .resume(resume), .sw(sw), .halt(halt),
        .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5)
    );

    assign hexOut[0] = hex0;
    assign hexOut[1] = hex1;
    assign hexOut[2] = hex2;
    assign hexOut[3] = hex3;
    assign hexOut[4] = hex4;
    assign hexOut[5] = hex5;

    task automatic stopOnFailure();
        $display("TEST FAILED");
        $fatal(1, "Stopping at the first failed check");
    endtask

    `include "benchTasks.svh"

    function automatic busWord_t regAddr(input logic [7:0] ofs);
        regAddr = {MMIO_BASE, ofs};
    endfunction

    // Galois right shift with the mask folded in when a one drops out
    function automatic busWord_t nextLfsr(input busWord_t state);
        nextLfsr = state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    // Lit segments gfedcba inverted for the active-low digits
    function automatic logic [SEG_WIDTH-1:0] segmentsFor(input logic [3:0] nib);
        logic [SEG_WIDTH-1:0] lit;
        case (nib)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        segmentsFor = ~lit;
    endfunction

    // All six digits against the low nibbles of the shown word
    task automatic checkDigits(input string name, input busWord_t shown);
        for (int d = 0; d < NUM_DIGITS; d++) begin
            checkSegments($sformatf("%s hex%0d", name, d), segmentsFor(shown[4*d +: 4]),
                          hexOut[d]);
        end
    endtask

    task automatic addStep(input string name, input int op, input busWord_t addr,
                           input busWord_t data, input busWord_t expected, input int check);
        stepName[numSteps]   = name;
        stepOp[numSteps]     = op;
        stepAddr[numSteps]   = addr;
        stepData[numSteps]   = data;
        stepExpect[numSteps] = expected;
        stepCheck[numSteps]  = check;
        numSteps++;
    endtask

    task automatic buildTable();
        busWord_t dbgValue;
        dbgValue = $random(seed);
        addStep("reset halt", OP_IDLE, '0, 32'd1, 32'h0, CHK_LEVEL);
        // Bus basics
        addStep("debug write", OP_WRITE, regAddr(DEBUG_OFS), dbgValue, '0, CHK_NONE);
        addStep("debug read", OP_READ, regAddr(DEBUG_OFS), '0, dbgValue, CHK_WORD);
        // Foreign page carrying the debug offset must not alias
        addStep("unmapped read", OP_READ, 32'h0000_0030, '0, 32'h0, CHK_WORD);
        // LFSR sequence from the seed
        addStep("lfsr read 0", OP_READ, regAddr(LFSR_OFS), '0, '0, CHK_LFSR);
        addStep("lfsr read 1", OP_READ, regAddr(LFSR_OFS), '0, '0, CHK_LFSR);
        addStep("lfsr read 2", OP_READ, regAddr(LFSR_OFS), '0, '0, CHK_LFSR);
        // Stopwatch start, stop, clear
        addStep("sw start", OP_WRITE, regAddr(SW_CTRL_OFS), 32'h1 << SW_RUN_BIT, '0, CHK_NONE);
        addStep("sw wait 1", OP_IDLE, '0, 32'd8, '0, CHK_NONE);
        addStep("sw running 1", OP_READ, regAddr(SW_COUNT_OFS), '0, 32'h1, CHK_MIN);
        addStep("sw wait 2", OP_IDLE, '0, 32'd8, '0, CHK_NONE);
        addStep("sw running 2", OP_READ, regAddr(SW_COUNT_OFS), '0, '0, CHK_GEPREV);
        addStep("sw stop", OP_WRITE, regAddr(SW_CTRL_OFS), 32'h0, '0, CHK_NONE);
        addStep("sw stopped 1", OP_READ, regAddr(SW_COUNT_OFS), '0, '0, CHK_NONE);
        addStep("sw wait 3", OP_IDLE, '0, 32'd8, '0, CHK_NONE);
        addStep("sw stopped 2", OP_READ, regAddr(SW_COUNT_OFS), '0, '0, CHK_SAME);
        addStep("sw clear", OP_WRITE, regAddr(SW_CTRL_OFS), 32'h1 << SW_CLEAR_BIT, '0,
                CHK_NONE);
        addStep("sw cleared", OP_READ, regAddr(SW_COUNT_OFS), '0, 32'h0, CHK_WORD);
        // Breakpoint halt, resume, re-arm and disable
        addStep("brk addr", OP_WRITE, regAddr(BRK_ADDR_OFS), 32'h100, '0, CHK_NONE);
        addStep("brk enable", OP_WRITE, regAddr(BRK_CTRL_OFS), 32'h1 << BRK_EN_BIT, '0,
                CHK_NONE);
        addStep("pc to break", OP_PC, '0, 32'h100, '0, CHK_NONE);
        addStep("halt rises", OP_IDLE, '0, 32'd3, 32'h1, CHK_LEVEL);
        addStep("halt holds", OP_IDLE, '0, 32'd8, 32'h1, CHK_LEVEL);
        addStep("resume", OP_RESUME, '0, '0, 32'h0, CHK_LEVEL);
        addStep("no re-halt", OP_IDLE, '0, 32'd8, 32'h0, CHK_LEVEL);
        addStep("pc leaves", OP_PC, '0, 32'h104, 32'h0, CHK_LEVEL);
        addStep("pc returns", OP_PC, '0, 32'h100, '0, CHK_NONE);
        addStep("halt again", OP_IDLE, '0, 32'd3, 32'h1, CHK_LEVEL);
        addStep("resume again", OP_RESUME, '0, '0, 32'h0, CHK_LEVEL);
        addStep("pc away", OP_PC, '0, 32'h200, '0, CHK_NONE);
        addStep("brk disable", OP_WRITE, regAddr(BRK_CTRL_OFS), 32'h0, '0, CHK_NONE);
        addStep("pc to break off", OP_PC, '0, 32'h100, '0, CHK_NONE);
        addStep("disabled no halt", OP_IDLE, '0, 32'd8, 32'h0, CHK_LEVEL);
        // Display sources
        addStep("pc pattern", OP_PC, '0, 32'hCA5B_6E81, '0, CHK_NONE);
        addStep("pc digits", OP_SW, '0, 32'(DISP_PC), 32'hCA5B_6E81, CHK_DIGITS);
        addStep("debug digits", OP_SW, '0, 32'(DISP_DEBUG), dbgValue, CHK_DIGITS);
        addStep("sw restart", OP_WRITE, regAddr(SW_CTRL_OFS), 32'h1 << SW_RUN_BIT, '0,
                CHK_NONE);
        addStep("status running", OP_SW, '0, 32'(DISP_STATUS), 32'h2, CHK_DIGITS);
        addStep("pc back to break", OP_PC, '0, 32'h100, '0, CHK_NONE);
        addStep("brk re-enable", OP_WRITE, regAddr(BRK_CTRL_OFS), 32'h1 << BRK_EN_BIT, '0,
                CHK_NONE);
        addStep("status halted", OP_IDLE, '0, 32'd3, 32'h3, CHK_DIGITS);
        tableBuilt = 1'b1;
    endtask

    // Watchdog allows twenty cycles per table entry
    initial begin
        wait (tableBuilt);
        repeat (numSteps * 20) @(posedge iCLK);
        $display("Watchdog expired, stimulus table still running after %0d cycles",
                 numSteps * 20);
        stopOnFailure();
    end

    initial begin
        busWord_t readValue;
        busWord_t prevRead;
        busWord_t lfsrModel;
        arstN       <= 1'b0;
        readEnable  <= 1'b0;
        writeEnable <= 1'b0;
        address     <= '0;
        writeData   <= '0;
        pc          <= '0;
        resume      <= 1'b0;
        sw          <= DISP_STATUS;
        readValue   = '0;
        prevRead    = '0;
        lfsrModel   = TB_SEED;
        buildTable();
        repeat (RESET_CYCLES) @(posedge iCLK);
        arstN <= 1'b1;
        for (int i = 0; i < numSteps; i++) begin
            case (stepOp[i])
                OP_READ:  busRead(stepAddr[i], readValue);
                OP_WRITE: busWrite(stepAddr[i], stepData[i]);
                OP_PC: begin
                    @(posedge iCLK);
                    pc <= stepData[i];
                end
                OP_SW: begin
                    @(posedge iCLK);
                    sw <= stepData[i][1:0];
                end
                OP_RESUME: begin
                    // One-cycle key press
                    @(posedge iCLK);
                    resume <= 1'b1;
                    @(posedge iCLK);
                    resume <= 1'b0;
                end
                default: repeat (stepData[i]) @(posedge iCLK);
            endcase
            // Reads already end mid-cycle
            if (stepOp[i] != OP_READ) begin
                @(negedge iCLK);
            end
            case (stepCheck[i])
                CHK_WORD:   checkWord(stepName[i], stepExpect[i], readValue);
                CHK_LFSR: begin
                    checkWord(stepName[i], lfsrModel, readValue);
                    lfsrModel = nextLfsr(lfsrModel);
                end
                CHK_MIN:    checkAtLeast(stepName[i], stepExpect[i], readValue);
                CHK_GEPREV: checkAtLeast(stepName[i], prevRead, readValue);
                CHK_SAME:   checkWord(stepName[i], prevRead, readValue);
                CHK_LEVEL:  checkLevel(stepName[i], stepExpect[i][0], halt);
                CHK_DIGITS: checkDigits(stepName[i], stepExpect[i]);
                default: ;
            endcase
            if (stepOp[i] == OP_READ) begin
                prevRead = readValue;
            end
        end
        $display("TEST OK");
        $finish;
    end

endmodule

/* hw/breakUnit.sv */
// **********************************************************************
// PC breakpoint, halt held until resume, re-armed once pc moves off
// **********************************************************************
`timescale 1ns/1ps

module breakUnit import busPkg::*; (
    input  logic     iCLK,
    input  logic     arstN,
    input  logic     brkAddrWrite,
    input  logic     brkCtrlWrite,
    input  busWord_t writeData,
    input  busWord_t pc,
    input  logic     resume,
    output busWord_t brkAddrData,
    output busWord_t brkCtrlData,
    output logic     halt
);

    busWord_t brkAddr;
    logic     brkEnable;
    logic     armed;
    logic     atBreak;

    assign atBreak = (pc == brkAddr);

    always_ff @(posedge iCLK or negedge arstN) begin
        if (!arstN) begin
            brkAddr   <= '0;
            brkEnable <= 1'b0;
            halt      <= 1'b0;
            armed     <= 1'b1;
        end else begin
            if (brkAddrWrite) begin
                brkAddr <= writeData;
            end
            if (brkCtrlWrite) begin
                brkEnable <= writeData[BRK_EN_BIT];
            end
            // Halt level, cleared only by resume
            if (halt) begin
                halt <= !resume;
            end else if (brkEnable && armed && atBreak) begin
                halt <= 1'b1;
            end
            // Disarm on resume, re-arm when pc leaves the break address
            if (!atBreak) begin
                armed <= 1'b1;
            end else if (halt && resume) begin
                armed <= 1'b0;
            end
        end
    end

    assign brkAddrData = brkAddr;

    always_comb begin
        brkCtrlData             = '0;
        brkCtrlData[BRK_EN_BIT] = brkEnable;
    end

    // Match was sampled with the old enable
    assert property (@(posedge iCLK) disable iff (!arstN) $rose(halt) |-> $past(brkEnable));

endmodule

/* hw/busDecoder.sv */
// **********************************************************************
// MMIO page decode into per-register strobes, plus registered read-back
// **********************************************************************
`timescale 1ns/1ps

module busDecoder import busPkg::*; (
    input  logic     iCLK,
    input  logic     arstN,
    input  logic     readEnable,
    input  logic     writeEnable,
    input  busWord_t address,
    input  busWord_t lfsrData,
    input  busWord_t swCtrlData,
    input  busWord_t swCountData,
    input  busWord_t brkAddrData,
    input  busWord_t brkCtrlData,
    input  busWord_t debugData,
    output logic     lfsrRead,
    output logic     swCtrlWrite,
    output logic     brkAddrWrite,
    output logic     brkCtrlWrite,
    output logic     debugWrite,
    output busWord_t readData
);

    logic     pageHit;
    logic     selLfsr, selSwCtrl, selSwCount, selBrkAddr, selBrkCtrl, selDebug;
    busWord_t readMux;

    // Page match on the upper address bits
    assign pageHit = (address[DATA_WIDTH-1:8] == MMIO_BASE);

    // One select per mapped offset
    assign selLfsr    = pageHit && (address[7:0] == LFSR_OFS);
    assign selSwCtrl  = pageHit && (address[7:0] == SW_CTRL_OFS);
    assign selSwCount = pageHit && (address[7:0] == SW_COUNT_OFS);
    assign selBrkAddr = pageHit && (address[7:0] == BRK_ADDR_OFS);
    assign selBrkCtrl = pageHit && (address[7:0] == BRK_CTRL_OFS);
    assign selDebug   = pageHit && (address[7:0] == DEBUG_OFS);

    // Strobes, whole-word writes only
    assign lfsrRead     = readEnable && selLfsr;
    assign swCtrlWrite  = writeEnable && selSwCtrl;
    assign brkAddrWrite = writeEnable && selBrkAddr;
    assign brkCtrlWrite = writeEnable && selBrkCtrl;
    assign debugWrite   = writeEnable && selDebug;

    // AND-OR mux, unmapped gives zero
    assign readMux = ({DATA_WIDTH{selLfsr}}    & lfsrData)
                   | ({DATA_WIDTH{selSwCtrl}}  & swCtrlData)
                   | ({DATA_WIDTH{selSwCount}} & swCountData)
                   | ({DATA_WIDTH{selBrkAddr}} & brkAddrData)
                   | ({DATA_WIDTH{selBrkCtrl}} & brkCtrlData)
                   | ({DATA_WIDTH{selDebug}}   & debugData);

    // Capture on the read strobe, hold until the next read
    always_ff @(posedge iCLK or negedge arstN) begin
        if (!arstN) begin
            readData <= '0;
        end else if (readEnable) begin
            readData <= readMux;
        end
    end

    // Processor never reads and writes in one cycle
    assert property (@(posedge iCLK) disable iff (!arstN) !(readEnable && writeEnable));

endmodule

/* hw/busPkg.sv */
// **********************************************************************
// Data bus widths and the peripheral register map of the MMIO page
// Imported by the decoder and every bus-attached peripheral
// **********************************************************************

package busPkg;

    // Bus word and program counter width
    localparam int DATA_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0] busWord_t;

    // Upper 24 address bits common to the whole peripheral page
    localparam logic [23:0] MMIO_BASE = 24'hFF2000;

    // Register offsets inside the page
    localparam logic [7:0] LFSR_OFS     = 8'h00;
    localparam logic [7:0] SW_CTRL_OFS  = 8'h10;
    localparam logic [7:0] SW_COUNT_OFS = 8'h14;
    localparam logic [7:0] BRK_ADDR_OFS = 8'h20;
    localparam logic [7:0] BRK_CTRL_OFS = 8'h24;
    localparam logic [7:0] DEBUG_OFS    = 8'h30;

    // Stopwatch control word bits
    localparam int SW_RUN_BIT   = 0;
    localparam int SW_CLEAR_BIT = 1;

    // Breakpoint control word bit
    localparam int BRK_EN_BIT = 0;

endpackage

/* hw/displayPkg.sv */
// **********************************************************************
// Seven-segment display sizes, source select codes and word views
// **********************************************************************

package displayPkg;

    // Six digits on the board, seven segments each
    localparam int NUM_DIGITS = 6;
    localparam int SEG_WIDTH  = 7;

    // Switch codes choosing the displayed word
    localparam logic [1:0] DISP_STATUS = 2'd0;
    localparam logic [1:0] DISP_DEBUG  = 2'd1;
    // Code 2 is unused and blanks to zero
    localparam logic [1:0] DISP_PC     = 2'd3;

    // One display word, seen whole or as hex nibbles
    typedef union packed {
        // Whole word as picked by the source mux
        logic [31:0] raw;
        // Nibble 0 is the rightmost digit
        logic [7:0][3:0] nibble;
    } displayWord_u;

    // Segment encoding
    // Active low, bit 0 is segment a, bit 6 is segment g
    // Glyph table itself sits in the display module

endpackage

/* hw/hexDisplay.sv */
// **********************************************************************
// Debug register and six-digit hex display, source picked by two switches
// **********************************************************************
`timescale 1ns/1ps

module hexDisplay import busPkg::*, displayPkg::*; (
    input  logic                 iCLK,
    input  logic                 arstN,
    input  logic                 debugWrite,
    input  busWord_t             writeData,
    input  busWord_t             pc,
    input  logic [1:0]           sw,
    input  logic                 running,
    input  logic                 halt,
    output busWord_t             debugData,
    output logic [SEG_WIDTH-1:0] hex0,
    output logic [SEG_WIDTH-1:0] hex1,
    output logic [SEG_WIDTH-1:0] hex2,
    output logic [SEG_WIDTH-1:0] hex3,
    output logic [SEG_WIDTH-1:0] hex4,
    output logic [SEG_WIDTH-1:0] hex5
);

    busWord_t             debugReg;
    logic [7:0]           statusByte;
    displayWord_u         dispWord;
    logic [SEG_WIDTH-1:0] segs [NUM_DIGITS];

    // Hex glyph, gfedcba, active low
    function automatic logic [SEG_WIDTH-1:0] hexGlyph(input logic [3:0] nib);
        case (nib)
            4'h0: hexGlyph = 7'h40;
            4'h1: hexGlyph = 7'h79;
            4'h2: hexGlyph = 7'h24;
            4'h3: hexGlyph = 7'h30;
            4'h4: hexGlyph = 7'h19;
            4'h5: hexGlyph = 7'h12;
            4'h6: hexGlyph = 7'h02;
            4'h7: hexGlyph = 7'h78;
            4'h8: hexGlyph = 7'h00;
            4'h9: hexGlyph = 7'h10;
            4'hA: hexGlyph = 7'h08;
            4'hB: hexGlyph = 7'h03;
            4'hC: hexGlyph = 7'h46;
            4'hD: hexGlyph = 7'h21;
            4'hE: hexGlyph = 7'h06;
            default: hexGlyph = 7'h0E;
        endcase
    endfunction

    always_ff @(posedge iCLK or negedge arstN) begin
        if (!arstN) begin
            debugReg <= '0;
        end else if (debugWrite) begin
            debugReg <= writeData;
        end
    end

    assign debugData  = debugReg;
    assign statusByte = {6'b0, running, halt};

    // Source select on the raw view
    always_comb begin
        case (sw)
            DISP_STATUS: dispWord.raw = {24'b0, statusByte};
            DISP_DEBUG:  dispWord.raw = debugReg;
            DISP_PC:     dispWord.raw = pc;
            default:     dispWord.raw = '0;
        endcase
    end

    // Low nibbles only, top two never shown
    for (genvar i = 0; i < NUM_DIGITS; i++) begin : gDigit
        assign segs[i] = hexGlyph(dispWord.nibble[i]);
    end

    assign hex0 = segs[0];
    assign hex1 = segs[1];
    assign hex2 = segs[2];
    assign hex3 = segs[3];
    assign hex4 = segs[4];
    assign hex5 = segs[5];

endmodule

/* hw/lfsrRng.sv */
// **********************************************************************
// 32-bit Galois LFSR read as a register, one step per bus read
// **********************************************************************
`timescale 1ns/1ps

module lfsrRng import busPkg::*; #(
    parameter busWord_t LFSR_SEED = 32'h1
) (
    input  logic     iCLK,
    input  logic     arstN,
    input  logic     lfsrRead,
    output busWord_t lfsrData
);

    // Feedback mask applied when bit 0 shifts out
    localparam busWord_t LFSR_TAPS = 32'h80200003;

    busWord_t lfsrState;

    always_ff @(posedge iCLK or negedge arstN) begin
        if (!arstN) begin
            lfsrState <= LFSR_SEED;
        end else if (lfsrRead) begin
            // Right shift, taps folded in on a one
            if (lfsrState[0]) begin
                lfsrState <= (lfsrState >> 1) ^ LFSR_TAPS;
            end else begin
                lfsrState <= lfsrState >> 1;
            end
        end
    end

    // Decoder samples this on the same edge, so reads see the pre-step value
    assign lfsrData = lfsrState;

    // All-zero state would lock the sequence up
    assert property (@(posedge iCLK) disable iff (!arstN) lfsrState != '0);

endmodule

/* hw/peripheralTop.sv */
// **********************************************************************
// Peripheral side of the teaching board, driven by an external CPU bus
// Connects the decoder, LFSR, stopwatch, breakpoint unit and display
// **********************************************************************
`timescale 1ns/1ps

module peripheralTop import busPkg::*, displayPkg::*; #(
    parameter busWord_t LFSR_SEED = 32'h1,
    parameter int       TICK_DIV  = 4
) (
    input  logic                 iCLK,
    input  logic                 arstN,
    // Data bus from the processor
    input  logic                 readEnable,
    input  logic                 writeEnable,
    input  busWord_t             address,
    input  busWord_t             writeData,
    output busWord_t             readData,
    // Debug inputs
    input  busWord_t             pc,
    input  logic                 resume,
    input  logic [1:0]           sw,
    output logic                 halt,
    // Seven-segment digits
    output logic [SEG_WIDTH-1:0] hex0,
    output logic [SEG_WIDTH-1:0] hex1,
    output logic [SEG_WIDTH-1:0] hex2,
    output logic [SEG_WIDTH-1:0] hex3,
    output logic [SEG_WIDTH-1:0] hex4,
    output logic [SEG_WIDTH-1:0] hex5
);

    // Read-back words, one per register
    busWord_t lfsrData;
    busWord_t swCtrlData;
    busWord_t swCountData;
    busWord_t brkAddrData;
    busWord_t brkCtrlData;
    busWord_t debugData;

    // Strobes from the decoder
    logic lfsrRead;
    logic swCtrlWrite;
    logic brkAddrWrite;
    logic brkCtrlWrite;
    logic debugWrite;

    // Stopwatch state for the status byte
    logic running;

    busDecoder decoder0 (
        .iCLK(iCLK), .arstN(arstN),
        .readEnable(readEnable), .writeEnable(writeEnable), .address(address),
        .lfsrData(lfsrData), .swCtrlData(swCtrlData), .swCountData(swCountData),
        .brkAddrData(brkAddrData), .brkCtrlData(brkCtrlData), .debugData(debugData),
        .lfsrRead(lfsrRead), .swCtrlWrite(swCtrlWrite), .brkAddrWrite(brkAddrWrite),
        .brkCtrlWrite(brkCtrlWrite), .debugWrite(debugWrite), .readData(readData)
    );

    lfsrRng #(.LFSR_SEED(LFSR_SEED)) lfsr0 (
        .iCLK(iCLK), .arstN(arstN), .lfsrRead(lfsrRead), .lfsrData(lfsrData)
    );

    stopwatch #(.TICK_DIV(TICK_DIV)) stopwatch0 (
        .iCLK(iCLK), .arstN(arstN), .swCtrlWrite(swCtrlWrite), .writeData(writeData),
        .swCtrlData(swCtrlData), .swCountData(swCountData), .running(running)
    );

    breakUnit break0 (
        .iCLK(iCLK), .arstN(arstN), .brkAddrWrite(brkAddrWrite),
        .brkCtrlWrite(brkCtrlWrite), .writeData(writeData), .pc(pc), .resume(resume),
        .brkAddrData(brkAddrData), .brkCtrlData(brkCtrlData), .halt(halt)
    );

    hexDisplay display0 (
        .iCLK(iCLK), .arstN(arstN), .debugWrite(debugWrite), .writeData(writeData),
        .pc(pc), .sw(sw), .running(running), .halt(halt), .debugData(debugData),
        .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5)
    );

endmodule

/* hw/stopwatch.sv */
// **********************************************************************
// Stopwatch counting prescaled ticks, run and clear via control writes
// **********************************************************************
`timescale 1ns/1ps

module stopwatch import busPkg::*; #(
    parameter int TICK_DIV = 4
) (
    input  logic     iCLK,
    input  logic     arstN,
    input  logic     swCtrlWrite,
    input  busWord_t writeData,
    output busWord_t swCtrlData,
    output busWord_t swCountData,
    output logic     running
);

    // Prescaler needs at least one bit
    localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PRE_W-1:0] prescale;
    busWord_t         count;
    logic             clearNow;

    // Clear only lives in its write cycle
    assign clearNow = swCtrlWrite && writeData[SW_CLEAR_BIT];

    always_ff @(posedge iCLK or negedge arstN) begin
        if (!arstN) begin
            running  <= 1'b0;
            prescale <= '0;
            count    <= '0;
        end else begin
            if (swCtrlWrite) begin
                running <= writeData[SW_RUN_BIT];
            end
            if (clearNow) begin
                prescale <= '0;
                count    <= '0;
            end else if (running) begin
                // One count every TICK_DIV cycles
                if (prescale == PRE_W'(TICK_DIV - 1)) begin
                    prescale <= '0;
                    count    <= count + 1'b1;
                end else begin
                    prescale <= prescale + 1'b1;
                end
            end
        end
    end

    // Control reads back only the run flag
    always_comb begin
        swCtrlData             = '0;
        swCtrlData[SW_RUN_BIT] = running;
    end

    assign swCountData = count;

endmodule

/* verilog.f */
+incdir+bench
hw/busPkg.sv
hw/displayPkg.sv
hw/busDecoder.sv
hw/lfsrRng.sv
hw/stopwatch.sv
hw/breakUnit.sv
hw/hexDisplay.sv
hw/peripheralTop.sv
bench/peripheralTb.sv
